//--- Makefile
SIM       = verilator
TOP       = tri_setup_tb
FILELIST  = tb.f
OBJ_DIR   = obj_dir
FLAGS     = --binary --assert -Wno-fatal -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
RUN_FLAGS = +verilator+error+limit+1000
BIN       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
PASS_MSG  = All tests passed!
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUN_FLAGS) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- src/bbox_calc.sv
`timescale 1ns/100ps

module bbox_calc #(
  parameter int XWIDTH = fixed_pkg::DEF_XWIDTH,
  parameter int YWIDTH = fixed_pkg::DEF_YWIDTH,
  parameter int FRAC = fixed_pkg::DEF_FRAC
) (
  input  logic                                clk_in,
  input  logic                                rst_in,
  input  logic                                valid_in,
  input  logic signed [XWIDTH-1:0]            x0,
  input  logic signed [XWIDTH-1:0]            x1,
  input  logic signed [XWIDTH-1:0]            x2,
  input  logic signed [YWIDTH-1:0]            y0,
  input  logic signed [YWIDTH-1:0]            y1,
  input  logic signed [YWIDTH-1:0]            y2,
  output logic                                valid_out,
  output logic [raster_pkg::PIX_X_WIDTH-1:0] min_x,
  output logic [raster_pkg::PIX_X_WIDTH-1:0] max_x,
  output logic [raster_pkg::PIX_Y_WIDTH-1:0] min_y,
  output logic [raster_pkg::PIX_Y_WIDTH-1:0] max_y
);
  import fixed_pkg::*;
  import raster_pkg::*;

  localparam int IX_WIDTH = XWIDTH - FRAC;
  localparam int IY_WIDTH = YWIDTH - FRAC;

  logic signed [IX_WIDTH-1:0] ix [VERTS];
  logic signed [IY_WIDTH-1:0] iy [VERTS];
  logic s1_valid;
  logic signed [IX_WIDTH-1:0] lo_x;
  logic signed [IX_WIDTH-1:0] hi_x;
  logic signed [IY_WIDTH-1:0] lo_y;
  logic signed [IY_WIDTH-1:0] hi_y;

  function automatic int clamp(input int v, input int hi);
    if (v < 0) begin
      return 0;
    end
    return (v > hi) ? hi : v;
  endfunction

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      s1_valid <= 1'b0;
      valid_out <= 1'b0;
    end else begin
      s1_valid <= valid_in;
      valid_out <= s1_valid;
    end
  end

  always_ff @(posedge clk_in) begin
    ix[0] <= x0[XWIDTH-1:FRAC];  // upper bits are the floor.
    ix[1] <= x1[XWIDTH-1:FRAC];
    ix[2] <= x2[XWIDTH-1:FRAC];
    iy[0] <= y0[YWIDTH-1:FRAC];
    iy[1] <= y1[YWIDTH-1:FRAC];
    iy[2] <= y2[YWIDTH-1:FRAC];
  end

  always_comb begin
    lo_x = ix[0];
    hi_x = ix[0];
    lo_y = iy[0];
    hi_y = iy[0];
    for (int i = 1; i < VERTS; i++) begin
      if (ix[i] < lo_x) lo_x = ix[i];
      if (ix[i] > hi_x) hi_x = ix[i];
      if (iy[i] < lo_y) lo_y = iy[i];
      if (iy[i] > hi_y) hi_y = iy[i];
    end
  end

  always_ff @(posedge clk_in) begin
    min_x <= PIX_X_WIDTH'(clamp(int'(lo_x), SCREEN_W - 1));
    max_x <= PIX_X_WIDTH'(clamp(int'(hi_x), SCREEN_W - 1));
    min_y <= PIX_Y_WIDTH'(clamp(int'(lo_y), SCREEN_H - 1));
    max_y <= PIX_Y_WIDTH'(clamp(int'(hi_y), SCREEN_H - 1));
  end

endmodule

//--- src/fixed_div.sv
`timescale 1ns/100ps

module fixed_div #(
  parameter int WIDTH = 2 * fixed_pkg::DEF_XWIDTH,
  parameter int FRAC_BITS = 2 * fixed_pkg::DEF_FRAC
) (
  input  logic             clk_in,
  input  logic             rst_in,
  input  logic             valid_in,
  input  logic [WIDTH-1:0] a,
  input  logic [WIDTH-1:0] b,
  output logic [WIDTH-1:0] q,
  output logic             done,
  output logic             zerodiv,
  output logic             overflow
);
  localparam int N = WIDTH + FRAC_BITS;
  localparam int CNT_WIDTH = $clog2(N + 1);

  logic [N-1:0] num;  // dividend bits shift out as quotient bits shift in.
  logic [WIDTH-1:0] den;
  logic [WIDTH-1:0] rem;
  logic [WIDTH:0] rem_sh;
  logic q_bit;
  logic [WIDTH-1:0] rem_next;
  logic [N-1:0] num_next;
  logic ovf_next;
  logic [CNT_WIDTH-1:0] cnt;  // iterations left or zero when idle.
  logic start;

  assign start = valid_in && (cnt == '0);

  assign rem_sh = {rem, num[N-1]};
  assign q_bit = (rem_sh >= {1'b0, den});
  assign rem_next = q_bit ? WIDTH'(rem_sh - {1'b0, den}) : rem_sh[WIDTH-1:0];
  assign num_next = {num[N-2:0], q_bit};
  assign ovf_next = |num_next[N-1:WIDTH];  // integer part too wide.

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      cnt <= '0;
      done <= 1'b0;
      zerodiv <= 1'b0;
      overflow <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        if (b == '0) begin
          done <= 1'b1;  // no iterations needed.
          zerodiv <= 1'b1;
          overflow <= 1'b0;
        end else begin
          cnt <= CNT_WIDTH'(N);
          zerodiv <= 1'b0;
        end
      end else if (cnt != '0) begin
        cnt <= cnt - 1'b1;
        if (cnt == CNT_WIDTH'(1)) begin
          done <= 1'b1;
          overflow <= ovf_next;
        end
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (start) begin
      num <= {a, {FRAC_BITS{1'b0}}};
      den <= b;
      rem <= '0;
      if (b == '0) begin
        q <= '1;
      end
    end else if (cnt != '0) begin
      num <= num_next;
      rem <= rem_next;
      if (cnt == CNT_WIDTH'(1)) begin
        q <= ovf_next ? '1 : num_next[WIDTH-1:0];  // saturate.
      end
    end
  end

endmodule

//--- src/fixed_pkg.sv
package fixed_pkg;

  // the shoelace form is written for triangles only.
  localparam int VERTS = 3;

  // default signed Q8.8 coordinate format.
  localparam int DEF_XWIDTH = 16;
  localparam int DEF_YWIDTH = 16;
  localparam int DEF_FRAC = 8;

endpackage : fixed_pkg

//--- src/inv_area.sv
`timescale 1ns/100ps

module inv_area #(
  parameter int XWIDTH = fixed_pkg::DEF_XWIDTH,
  parameter int YWIDTH = fixed_pkg::DEF_YWIDTH,
  parameter int FRAC = fixed_pkg::DEF_FRAC,
  localparam int SUB_WIDTH = YWIDTH + 1,
  localparam int DOT_WIDTH = (XWIDTH - FRAC) + (SUB_WIDTH - FRAC) + FRAC + 2,
  localparam int DOT_INT = DOT_WIDTH - FRAC,
  localparam int INV_WIDTH = 2 * (DOT_INT > FRAC ? DOT_INT : FRAC) + 1
) (
  input  logic                     clk_in,
  input  logic                     rst_in,
  input  logic                     valid_in,
  input  logic signed [XWIDTH-1:0] x0,
  input  logic signed [XWIDTH-1:0] x1,
  input  logic signed [XWIDTH-1:0] x2,
  input  logic signed [YWIDTH-1:0] y0,
  input  logic signed [YWIDTH-1:0] y1,
  input  logic signed [YWIDTH-1:0] y2,
  output logic                     done,
  output logic [INV_WIDTH-1:0]     iarea,
  output logic                     clockwise,
  output logic                     zero_area,
  output logic                     overflow
);
  import fixed_pkg::*;

  localparam int INV_FRAC = 2 * FRAC;
  localparam logic [INV_WIDTH-1:0] FIX_ONE = 1 << FRAC;

  enum logic [1:0] {IDLE, DOT, DIV} state;

  logic signed [VERTS-1:0][XWIDTH-1:0] xv;
  logic signed [VERTS-1:0][SUB_WIDTH-1:0] dy;
  logic dot_start;
  logic dot_valid;
  logic signed [DOT_WIDTH-1:0] dot_p;
  logic [INV_WIDTH-1:0] dot_mag;
  logic [INV_WIDTH-1:0] div_q;
  logic div_done;
  logic div_zerodiv;
  logic div_overflow;

  assign dot_mag = dot_p[DOT_WIDTH-1] ? INV_WIDTH'(-dot_p) : INV_WIDTH'(dot_p);

  slow_dot #(
    .A_WIDTH(XWIDTH),
    .B_WIDTH(SUB_WIDTH),
    .FRAC(FRAC)
  ) dot_i (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .valid_in(dot_start),
    .a(xv),
    .b(dy),
    .valid_out(dot_valid),
    .p(dot_p)
  );

  fixed_div #(
    .WIDTH(INV_WIDTH),
    .FRAC_BITS(INV_FRAC)
  ) div_i (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .valid_in(dot_valid),
    .a(FIX_ONE),
    .b(dot_mag),
    .q(div_q),
    .done(div_done),
    .zerodiv(div_zerodiv),
    .overflow(div_overflow)
  );

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= IDLE;
      dot_start <= 1'b0;
      done <= 1'b0;
    end else begin
      dot_start <= 1'b0;
      done <= 1'b0;
      case (state)
        IDLE: begin
          if (valid_in) begin
            state <= DOT;
            dot_start <= 1'b1;
          end
        end
        DOT: begin
          if (dot_valid) begin
            state <= DIV;
          end
        end
        DIV: begin
          if (div_done) begin
            state <= IDLE;
            done <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (state == IDLE && valid_in) begin
      xv <= {x2, x1, x0};
      dy[0] <= y1 - y2;
      dy[1] <= y2 - y0;
      dy[2] <= y0 - y1;
    end
    if (state == DOT && dot_valid) begin
      clockwise <= dot_p[DOT_WIDTH-1];  // negative area.
    end
    if (state == DIV && div_done) begin
      iarea <= div_q;
      zero_area <= div_zerodiv;
      overflow <= div_overflow;
    end
  end

endmodule

//--- src/raster_pkg.sv
package raster_pkg;

  // target screen in pixels.
  localparam int SCREEN_W = 320;
  localparam int SCREEN_H = 240;

  localparam int PIX_X_WIDTH = $clog2(SCREEN_W);  // 0..319.
  localparam int PIX_Y_WIDTH = $clog2(SCREEN_H);  // 0..239.

endpackage : raster_pkg

//--- src/setup_merge.sv
`timescale 1ns/100ps

module setup_merge #(
  parameter int INV_WIDTH = 2 * fixed_pkg::DEF_XWIDTH
) (
  input  logic                               clk_in,
  input  logic                               rst_in,
  input  logic                               bbox_valid,
  input  logic [raster_pkg::PIX_X_WIDTH-1:0] min_x_in,
  input  logic [raster_pkg::PIX_X_WIDTH-1:0] max_x_in,
  input  logic [raster_pkg::PIX_Y_WIDTH-1:0] min_y_in,
  input  logic [raster_pkg::PIX_Y_WIDTH-1:0] max_y_in,
  input  logic                               area_done,
  input  logic [INV_WIDTH-1:0]               iarea_in,
  input  logic                               clockwise,
  input  logic                               zero_area,
  input  logic                               overflow,
  input  logic                               cull_back,
  output logic                               valid_out,
  output logic [raster_pkg::PIX_X_WIDTH-1:0] min_x,
  output logic [raster_pkg::PIX_X_WIDTH-1:0] max_x,
  output logic [raster_pkg::PIX_Y_WIDTH-1:0] min_y,
  output logic [raster_pkg::PIX_Y_WIDTH-1:0] max_y,
  output logic [INV_WIDTH-1:0]               iarea,
  output logic                               culled
);
  import raster_pkg::*;

  logic pending;
  logic [PIX_X_WIDTH-1:0] hold_min_x;
  logic [PIX_X_WIDTH-1:0] hold_max_x;
  logic [PIX_Y_WIDTH-1:0] hold_min_y;
  logic [PIX_Y_WIDTH-1:0] hold_max_y;
  logic cull_now;
  logic emit;

  assign cull_now = zero_area | overflow | (cull_back & clockwise);
  assign emit = area_done & (pending | bbox_valid);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      pending <= 1'b0;
      valid_out <= 1'b0;
      culled <= 1'b0;
    end else begin
      valid_out <= emit;
      if (emit) begin
        pending <= 1'b0;
        culled <= cull_now;
      end else if (bbox_valid) begin
        pending <= 1'b1;  // box waits for the area result.
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (bbox_valid) begin
      hold_min_x <= min_x_in;
      hold_max_x <= max_x_in;
      hold_min_y <= min_y_in;
      hold_max_y <= max_y_in;
    end
    if (emit) begin
      min_x <= bbox_valid ? min_x_in : hold_min_x;
      max_x <= bbox_valid ? max_x_in : hold_max_x;
      min_y <= bbox_valid ? min_y_in : hold_min_y;
      max_y <= bbox_valid ? max_y_in : hold_max_y;
      iarea <= cull_now ? '0 : iarea_in;
    end
  end

endmodule

//--- src/slow_dot.sv
`timescale 1ns/100ps

module slow_dot #(
  parameter int A_WIDTH = fixed_pkg::DEF_XWIDTH,
  parameter int B_WIDTH = fixed_pkg::DEF_YWIDTH + 1,
  parameter int FRAC = fixed_pkg::DEF_FRAC,
  localparam int DOT_WIDTH = (A_WIDTH - FRAC) + (B_WIDTH - FRAC) + FRAC + 2
) (
  input  logic                                            clk_in,
  input  logic                                            rst_in,
  input  logic                                            valid_in,
  input  logic signed [fixed_pkg::VERTS-1:0][A_WIDTH-1:0] a,
  input  logic signed [fixed_pkg::VERTS-1:0][B_WIDTH-1:0] b,
  output logic                                            valid_out,
  output logic signed [DOT_WIDTH-1:0]                     p
);
  import fixed_pkg::*;

  localparam int ACC_WIDTH = A_WIDTH + B_WIDTH + 2;
  localparam int CNT_WIDTH = $clog2(VERTS);
  localparam int LAST = VERTS - 1;

  logic signed [VERTS-1:0][A_WIDTH-1:0] a_r;
  logic signed [VERTS-1:0][B_WIDTH-1:0] b_r;
  logic signed [ACC_WIDTH-1:0] acc;
  logic signed [ACC_WIDTH-1:0] term;
  logic signed [ACC_WIDTH-1:0] sum;
  logic [CNT_WIDTH-1:0] cnt;
  logic running;
  logic start;

  assign start = valid_in & ~running;
  assign term = $signed(a_r[cnt]) * $signed(b_r[cnt]);  // full precision.
  assign sum = acc + term;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      running <= 1'b0;
      cnt <= '0;
      valid_out <= 1'b0;
    end else begin
      valid_out <= 1'b0;
      if (start) begin
        running <= 1'b1;
        cnt <= '0;
      end else if (running) begin
        if (cnt == CNT_WIDTH'(LAST)) begin
          running <= 1'b0;
          valid_out <= 1'b1;
        end else begin
          cnt <= cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (start) begin
      a_r <= a;
      b_r <= b;
      acc <= '0;
    end else if (running) begin
      acc <= sum;
      if (cnt == CNT_WIDTH'(LAST)) begin
        p <= DOT_WIDTH'(sum >>> FRAC);  // floor back to FRAC bits.
      end
    end
  end

endmodule

//--- src/tri_setup.sv
`timescale 1ns/100ps

module tri_setup #(
  parameter int XWIDTH = fixed_pkg::DEF_XWIDTH,
  parameter int YWIDTH = fixed_pkg::DEF_YWIDTH,
  parameter int FRAC = fixed_pkg::DEF_FRAC,
  localparam int SUB_WIDTH = YWIDTH + 1,
  localparam int DOT_WIDTH = (XWIDTH - FRAC) + (SUB_WIDTH - FRAC) + FRAC + 2,
  localparam int DOT_INT = DOT_WIDTH - FRAC,
  localparam int INV_WIDTH = 2 * (DOT_INT > FRAC ? DOT_INT : FRAC) + 1
) (
  input  logic                               clk_in,
  input  logic                               rst_in,
  input  logic                               valid_in,
  input  logic signed [XWIDTH-1:0]           x0,
  input  logic signed [XWIDTH-1:0]           x1,
  input  logic signed [XWIDTH-1:0]           x2,
  input  logic signed [YWIDTH-1:0]           y0,
  input  logic signed [YWIDTH-1:0]           y1,
  input  logic signed [YWIDTH-1:0]           y2,
  input  logic                               cull_back,
  output logic                               busy,
  output logic                               valid_out,
  output logic [raster_pkg::PIX_X_WIDTH-1:0] min_x,
  output logic [raster_pkg::PIX_X_WIDTH-1:0] max_x,
  output logic [raster_pkg::PIX_Y_WIDTH-1:0] min_y,
  output logic [raster_pkg::PIX_Y_WIDTH-1:0] max_y,
  output logic [INV_WIDTH-1:0]               iarea,
  output logic                               culled
);
  import raster_pkg::*;

  logic accept;
  logic bbox_valid;
  logic [PIX_X_WIDTH-1:0] bb_min_x;
  logic [PIX_X_WIDTH-1:0] bb_max_x;
  logic [PIX_Y_WIDTH-1:0] bb_min_y;
  logic [PIX_Y_WIDTH-1:0] bb_max_y;
  logic area_done;
  logic [INV_WIDTH-1:0] area_iarea;
  logic area_cw;
  logic area_zero;
  logic area_ovf;

  assign accept = valid_in & ~busy;  // dropped while a triangle is in flight.

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy <= 1'b0;
    end else if (accept) begin
      busy <= 1'b1;
    end else if (valid_out) begin
      busy <= 1'b0;
    end
  end

  inv_area #(
    .XWIDTH(XWIDTH),
    .YWIDTH(YWIDTH),
    .FRAC(FRAC)
  ) inv_i (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .valid_in(accept),
    .x0(x0),
    .x1(x1),
    .x2(x2),
    .y0(y0),
    .y1(y1),
    .y2(y2),
    .done(area_done),
    .iarea(area_iarea),
    .clockwise(area_cw),
    .zero_area(area_zero),
    .overflow(area_ovf)
  );

  bbox_calc #(
    .XWIDTH(XWIDTH),
    .YWIDTH(YWIDTH),
    .FRAC(FRAC)
  ) bbox_i (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .valid_in(accept),
    .x0(x0),
    .x1(x1),
    .x2(x2),
    .y0(y0),
    .y1(y1),
    .y2(y2),
    .valid_out(bbox_valid),
    .min_x(bb_min_x),
    .max_x(bb_max_x),
    .min_y(bb_min_y),
    .max_y(bb_max_y)
  );

  setup_merge #(
    .INV_WIDTH(INV_WIDTH)
  ) merge_i (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .bbox_valid(bbox_valid),
    .min_x_in(bb_min_x),
    .max_x_in(bb_max_x),
    .min_y_in(bb_min_y),
    .max_y_in(bb_max_y),
    .area_done(area_done),
    .iarea_in(area_iarea),
    .clockwise(area_cw),
    .zero_area(area_zero),
    .overflow(area_ovf),
    .cull_back(cull_back),
    .valid_out(valid_out),
    .min_x(min_x),
    .max_x(max_x),
    .min_y(min_y),
    .max_y(max_y),
    .iarea(iarea),
    .culled(culled)
  );

endmodule

//--- tb.f
src/fixed_pkg.sv
src/raster_pkg.sv
src/slow_dot.sv
src/fixed_div.sv
src/inv_area.sv
src/bbox_calc.sv
src/setup_merge.sv
src/tri_setup.sv
verification/setup_checker.sv
verification/setup_monitor.sv
verification/tri_setup_tb.sv

//--- verification/setup_checker.sv
`timescale 1ns/100ps

module setup_checker (
  input logic clk_in,
  input logic rst_in,
  input logic valid_in,
  input logic busy,
  input logic area_done,
  input logic valid_out
);
  logic in_flight;  // an accepted triangle has no record yet.
  int fail_count = 0;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      in_flight <= 1'b0;
    end else if (valid_in && !busy) begin
      in_flight <= 1'b1;
    end else if (valid_out) begin
      in_flight <= 1'b0;
    end
  end

  single_pulse: assert property (@(posedge clk_in) disable iff (rst_in)
    valid_out |=> !valid_out)
    else begin
      $error("valid_out high two cycles in a row");
      fail_count++;
    end

  busy_at_done: assert property (@(posedge clk_in) disable iff (rst_in)
    area_done |-> busy)
    else begin
      $error("area_done while busy is low");
      fail_count++;
    end

  out_after_in: assert property (@(posedge clk_in) disable iff (rst_in)
    valid_out |-> in_flight)
    else begin
      $error("valid_out without an accepted valid_in");
      fail_count++;
    end

  quiet_in_reset: assert property (@(posedge clk_in) rst_in |=> !valid_out)
    else begin
      $error("valid_out high after a reset cycle");
      fail_count++;
    end

endmodule

bind tri_setup setup_checker chk_i (
  .clk_in(clk_in),
  .rst_in(rst_in),
  .valid_in(valid_in),
  .busy(busy),
  .area_done(area_done),
  .valid_out(valid_out)
);

//--- verification/setup_monitor.sv
`timescale 1ns/100ps

module setup_monitor #(
  parameter int INV_WIDTH = 2 * fixed_pkg::DEF_XWIDTH
) (
  input  logic                               clk_in,
  input  logic                               rst_in,
  input  logic                               valid_out,
  input  logic [raster_pkg::PIX_X_WIDTH-1:0] min_x,
  input  logic [raster_pkg::PIX_X_WIDTH-1:0] max_x,
  input  logic [raster_pkg::PIX_Y_WIDTH-1:0] min_y,
  input  logic [raster_pkg::PIX_Y_WIDTH-1:0] max_y,
  input  logic [INV_WIDTH-1:0]               iarea,
  input  logic                               culled
);
  import raster_pkg::*;

  // expected records in arrival order.
  string name_q[$];
  logic [PIX_X_WIDTH-1:0] min_x_q[$];
  logic [PIX_X_WIDTH-1:0] max_x_q[$];
  logic [PIX_Y_WIDTH-1:0] min_y_q[$];
  logic [PIX_Y_WIDTH-1:0] max_y_q[$];
  logic [INV_WIDTH-1:0] iarea_q[$];
  logic culled_q[$];
  int rec_count = 0;
  int err_count = 0;

  task automatic push_expect(input string name,
                             input logic [PIX_X_WIDTH-1:0] e_min_x,
                             input logic [PIX_X_WIDTH-1:0] e_max_x,
                             input logic [PIX_Y_WIDTH-1:0] e_min_y,
                             input logic [PIX_Y_WIDTH-1:0] e_max_y,
                             input logic [INV_WIDTH-1:0] e_iarea,
                             input logic e_culled);
    name_q.push_back(name);
    min_x_q.push_back(e_min_x);
    max_x_q.push_back(e_max_x);
    min_y_q.push_back(e_min_y);
    max_y_q.push_back(e_max_y);
    iarea_q.push_back(e_iarea);
    culled_q.push_back(e_culled);
  endtask

  task automatic report_missing(input string name);
    $display("%s: no valid_out arrived within the timeout", name);
    err_count++;
    if (name_q.size() != 0) begin
      void'(name_q.pop_front());  // stale expectation.
      void'(min_x_q.pop_front());
      void'(max_x_q.pop_front());
      void'(min_y_q.pop_front());
      void'(max_y_q.pop_front());
      void'(iarea_q.pop_front());
      void'(culled_q.pop_front());
    end
  endtask

  task automatic compare(input string name, input string field,
                         input longint exp, input longint act);
    if (exp != act) begin
      $display("ERR %s %s expected %0d actual %0d", name, field, exp, act);
      err_count++;
    end
  endtask

  always @(posedge clk_in) begin : check_record
    string name;
    if (!rst_in && valid_out) begin
      rec_count++;
      if (name_q.size() == 0) begin
        $display("valid_out seen with no triangle outstanding");
        err_count++;
      end else begin
        name = name_q.pop_front();
        compare(name, "min_x", longint'(min_x_q.pop_front()), longint'(min_x));
        compare(name, "max_x", longint'(max_x_q.pop_front()), longint'(max_x));
        compare(name, "min_y", longint'(min_y_q.pop_front()), longint'(min_y));
        compare(name, "max_y", longint'(max_y_q.pop_front()), longint'(max_y));
        compare(name, "iarea", longint'(iarea_q.pop_front()), longint'(iarea));
        compare(name, "culled", longint'(culled_q.pop_front()), longint'(culled));
      end
    end
  end

endmodule

//--- verification/tri_setup_tb.sv
`timescale 1ns/100ps

module tri_setup_tb;
  import fixed_pkg::*;
  import raster_pkg::*;

  localparam int XW = DEF_XWIDTH;
  localparam int YW = DEF_YWIDTH;
  localparam int FR = DEF_FRAC;
  localparam int SUB_WIDTH = YW + 1;
  localparam int DOT_WIDTH = (XW - FR) + (SUB_WIDTH - FR) + FR + 2;
  localparam int DOT_INT = DOT_WIDTH - FR;
  localparam int INV_WIDTH = 2 * (DOT_INT > FR ? DOT_INT : FR) + 1;
  localparam int INV_FRAC = 2 * FR;
  localparam int TIMEOUT = 400;  // well above the divider latency.
  localparam int N_RAND = 12;

  logic clk_in;
  logic rst_in;
  logic valid_in;
  logic cull_back;
  logic signed [XW-1:0] vx [VERTS];
  logic signed [YW-1:0] vy [VERTS];
  logic signed [XW-1:0] tx [VERTS];  // next triangle.
  logic signed [YW-1:0] ty [VERTS];
  logic busy;
  logic valid_out;
  logic [PIX_X_WIDTH-1:0] min_x;
  logic [PIX_X_WIDTH-1:0] max_x;
  logic [PIX_Y_WIDTH-1:0] min_y;
  logic [PIX_Y_WIDTH-1:0] max_y;
  logic [INV_WIDTH-1:0] iarea;
  logic culled;
  int tb_errors = 0;
  int tests_run = 0;
  int err_mark;
  int start;

  tri_setup dut_i (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .valid_in(valid_in),
    .x0(vx[0]),
    .x1(vx[1]),
    .x2(vx[2]),
    .y0(vy[0]),
    .y1(vy[1]),
    .y2(vy[2]),
    .cull_back(cull_back),
    .busy(busy),
    .valid_out(valid_out),
    .min_x(min_x),
    .max_x(max_x),
    .min_y(min_y),
    .max_y(max_y),
    .iarea(iarea),
    .culled(culled)
  );

  setup_monitor #(
    .INV_WIDTH(INV_WIDTH)
  ) mon_i (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .valid_out(valid_out),
    .min_x(min_x),
    .max_x(max_x),
    .min_y(min_y),
    .max_y(max_y),
    .iarea(iarea),
    .culled(culled)
  );

  initial begin
    clk_in = 1'b0;
    forever #10 clk_in = ~clk_in;
  end

  function automatic int err_total();
    return mon_i.err_count + tb_errors + dut_i.chk_i.fail_count;
  endfunction

  function automatic int rand_in(input int lo, input int hi);
    return lo + int'($urandom_range(hi - lo));
  endfunction

  function automatic longint clamp_pix(input longint v, input longint hi);
    if (v < 0) begin
      return 0;
    end
    return (v > hi) ? hi : v;
  endfunction

  // twice the signed area in full precision.
  function automatic longint area2();
    longint s;
    s = 0;
    for (int i = 0; i < VERTS; i++) begin
      s += longint'(tx[i]) *
           (longint'(ty[(i + 1) % VERTS]) - longint'(ty[(i + 2) % VERTS]));
    end
    return s;
  endfunction

  task automatic rand_tri(input int lo, input int hi);
    for (int i = 0; i < VERTS; i++) begin
      tx[i] = XW'(rand_in(lo, hi));
      ty[i] = YW'(rand_in(lo, hi));
    end
  endtask

  task automatic swap_verts();
    logic signed [XW-1:0] t;
    t = tx[1];
    tx[1] = tx[2];
    tx[2] = t;
    t = ty[1];
    ty[1] = ty[2];
    ty[2] = t;
  endtask

  // expected record for the triangle in tx/ty.
  task automatic predict(input string name);
    longint dot;
    longint mag;
    longint quo;
    longint lo_x;
    longint hi_x;
    longint lo_y;
    longint hi_y;
    longint px;
    longint py;
    bit cw;
    bit zero;
    bit ovf;
    bit cul;
    dot = area2() >>> FR;  // floor to FR fraction bits.
    cw = dot < 0;
    mag = cw ? -dot : dot;
    zero = mag == 0;
    quo = zero ? 0 : (longint'(1) << (FR + INV_FRAC)) / mag;
    ovf = quo >= (longint'(1) << INV_WIDTH);
    cul = zero || ovf || (cull_back && cw);
    lo_x = longint'(tx[0]) >>> FR;
    hi_x = lo_x;
    lo_y = longint'(ty[0]) >>> FR;
    hi_y = lo_y;
    for (int i = 1; i < VERTS; i++) begin
      px = longint'(tx[i]) >>> FR;
      py = longint'(ty[i]) >>> FR;
      lo_x = (px < lo_x) ? px : lo_x;
      hi_x = (px > hi_x) ? px : hi_x;
      lo_y = (py < lo_y) ? py : lo_y;
      hi_y = (py > hi_y) ? py : hi_y;
    end
    mon_i.push_expect(name,
                      PIX_X_WIDTH'(clamp_pix(lo_x, SCREEN_W - 1)),
                      PIX_X_WIDTH'(clamp_pix(hi_x, SCREEN_W - 1)),
                      PIX_Y_WIDTH'(clamp_pix(lo_y, SCREEN_H - 1)),
                      PIX_Y_WIDTH'(clamp_pix(hi_y, SCREEN_H - 1)),
                      cul ? '0 : INV_WIDTH'(quo), cul);
  endtask

  task automatic wait_record(input string name, input int first);
    int t;
    t = 0;
    while (mon_i.rec_count == first && t < TIMEOUT) begin
      @(negedge clk_in);
      t++;
    end
    if (mon_i.rec_count == first) begin
      mon_i.report_missing(name);
    end
  endtask

  task automatic wait_idle(input string name);
    int t;
    t = 0;
    while (busy && t < 20) begin
      @(negedge clk_in);
      t++;
    end
    if (busy) begin
      $display("%s: busy still high %0d cycles after the record", name, t);
      tb_errors++;
    end
  endtask

  task automatic apply(input string name, input bit cb);
    @(negedge clk_in);
    vx = tx;
    vy = ty;
    cull_back = cb;
    valid_in = 1'b1;
    predict(name);
  endtask

  task automatic send(input string name, input bit cb);
    int first;
    first = mon_i.rec_count;
    apply(name, cb);
    @(negedge clk_in);
    valid_in = 1'b0;
    wait_record(name, first);
    wait_idle(name);
  endtask

  task automatic end_test(input string name, input int mark, input int count);
    int errs;
    errs = err_total() - mark;
    tests_run++;
    $display("%s: %0d triangles, %0d errors", name, count, errs);
  endtask

  initial begin
    void'($urandom(32'hb136_269c));
    rst_in = 1'b1;
    valid_in = 1'b0;
    cull_back = 1'b0;
    for (int i = 0; i < VERTS; i++) begin
      vx[i] = '0;
      vy[i] = '0;
    end
    repeat (4) @(negedge clk_in);
    rst_in = 1'b0;

    err_mark = err_total();
    for (int i = 0; i < N_RAND; i++) begin
      rand_tri(0, 32767);
      if (area2() < 0) begin
        swap_verts();  // force counter-clockwise.
      end
      send("ccw", 1'b0);
    end
    end_test("ccw", err_mark, N_RAND);

    err_mark = err_total();
    for (int i = 0; i < N_RAND; i++) begin
      rand_tri(0, 32767);
      send("cull_back", 1'b1);
    end
    end_test("cull_back", err_mark, N_RAND);

    err_mark = err_total();
    for (int i = 0; i < 6; i++) begin
      rand_tri(0, 10000);
      if (i % 2 == 0) begin
        tx[1] = tx[0];  // repeated vertex.
        ty[1] = ty[0];
      end else begin
        tx[2] = XW'(2 * tx[1] - tx[0]);  // on the line through v0 and v1.
        ty[2] = YW'(2 * ty[1] - ty[0]);
      end
      send("degenerate", 1'b0);
    end
    end_test("degenerate", err_mark, 6);

    err_mark = err_total();
    for (int i = 0; i < 8; i++) begin
      rand_tri(0, 30000);
      for (int v = 1; v < VERTS; v++) begin
        tx[v] = XW'(tx[0] + rand_in(0, 3));
        ty[v] = YW'(ty[0] + rand_in(0, 3));
      end
      send("tiny", 1'b0);
    end
    end_test("tiny", err_mark, 8);

    err_mark = err_total();
    for (int i = 0; i < 8; i++) begin
      if (i == 0) begin
        rand_tri(-32768, -1);
      end else begin
        rand_tri(-32768, 32767);
      end
      send("clamp", 1'b0);
    end
    end_test("clamp", err_mark, 8);

    // second triangle arrives while the first is in flight.
    err_mark = err_total();
    start = mon_i.rec_count;
    rand_tri(0, 32767);
    apply("busy_drop", 1'b0);
    @(negedge clk_in);
    if (!busy) begin
      $display("ERR busy_drop busy expected 1 actual 0");
      tb_errors++;
    end
    rand_tri(0, 32767);
    vx = tx;
    vy = ty;
    @(negedge clk_in);
    valid_in = 1'b0;
    wait_record("busy_drop", start);
    wait_idle("busy_drop");
    for (int t = 0; t < 2 * TIMEOUT; t++) begin
      @(negedge clk_in);
    end
    if (mon_i.rec_count != start + 1) begin
      $display("ERR busy_drop records expected %0d actual %0d", 1,
               mon_i.rec_count - start);
      tb_errors++;
    end
    end_test("busy_drop", err_mark, 1);

    $display("%0d tests, %0d records, %0d errors", tests_run, mon_i.rec_count,
             err_total());
    if (err_total() == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
